// ==== vex_defs.svh ====
// ----------------------------
// widths and constants for the vector execute stage
// include in any file that sizes ports or struct fields
// ----------------------------

`ifndef VEX_DEFS_SVH
`define VEX_DEFS_SVH

// data word and scalar register width
`define VEX_XLEN 32

// vector register index
`define VEX_VREG_W 5

// element write offset within a register group
`define VEX_OFFSET_W 3

// segment field count and current field index
`define VEX_NF_W 3

// unit-stride step in bytes
`define VEX_DEFAULT_STRIDE 4

`endif

// ==== vex_pkg.sv ====
// ----------------------------
// types shared by the execute stage and its testbench
// decode issue bundle, memory bundle, ALU encodings
// ----------------------------

`include "vex_defs.svh"

package vex_pkg;

  typedef enum logic [1:0] {SEW8 = 2'd0, SEW16 = 2'd1, SEW32 = 2'd2} sew_t;

  // 2'd3 is not a legal source
  typedef enum logic [1:0] {V = 2'd0, I = 2'd1, X = 2'd2} src_type_t;

  typedef enum logic [2:0] {
    VALU_ADD = 3'd0,
    VALU_AND = 3'd1,
    VALU_OR  = 3'd2,
    VALU_XOR = 3'd3,
    VALU_MM  = 3'd4
  } valu_op_t;

  typedef enum logic [1:0] {MIN = 2'd0, MINU = 2'd1, MAX = 2'd2, MAXU = 2'd3} minmax_t;

  typedef enum logic [1:0] {UNIT = 2'd0, STRIDED = 2'd1, SEGMENT = 2'd2} stride_t;

  typedef enum logic [1:0] {NOT_VMV = 2'd0, V_V = 2'd1, S_X = 2'd2} vmv_t;

  // one data word seen whole or per element
  typedef union packed {
    logic [`VEX_XLEN-1:0] word;
    logic [1:0][15:0]     half;
    logic [3:0][7:0]      bytes;
  } vex_word_u;

  typedef struct packed {
    logic [`VEX_XLEN-1:0]   vs1_lane0;
    logic [`VEX_XLEN-1:0]   vs1_lane1;
    logic [`VEX_XLEN-1:0]   vs2_lane0;
    logic [`VEX_XLEN-1:0]   vs2_lane1;
    logic [`VEX_XLEN-1:0]   imm;
    logic [`VEX_XLEN-1:0]   xs1;
    logic [`VEX_XLEN-1:0]   xs2;
    logic [`VEX_XLEN-1:0]   stride_val;
    src_type_t              rs1_type;
    src_type_t              rs2_type;
    valu_op_t               aluop;
    minmax_t                minmax_type;
    sew_t                   sew;
    logic                   reduction_ena;
    logic                   load_ena;
    logic                   store_ena;
    logic                   ls_idx;
    stride_t                stride_type;
    // memory element width in bits (8, 16 or 32)
    logic [7:0]             eew_loadstore;
    logic [`VEX_NF_W-1:0]   nf;
    logic [`VEX_NF_W-1:0]   nf_count;
    logic                   fullreg;
    vmv_t                   vmv_type;
    logic [1:0]             wen;
    logic [`VEX_OFFSET_W-1:0] woffset0;
    logic [`VEX_OFFSET_W-1:0] woffset1;
    logic [`VEX_VREG_W-1:0] vd;
    logic                   rd_wen;
    logic [`VEX_VREG_W-1:0] rd_sel;
    logic                   rd_scalar_src;
    logic                   config_type;
    logic [`VEX_XLEN-1:0]   vl;
  } vex_issue_t;

  typedef struct packed {
    logic                   load_ena;
    logic                   store_ena;
    logic [`VEX_XLEN-1:0]   aluresult0;
    logic [`VEX_XLEN-1:0]   aluresult1;
    logic [1:0]             wen;
    logic [`VEX_OFFSET_W-1:0] woffset0;
    logic [`VEX_OFFSET_W-1:0] woffset1;
    logic [`VEX_VREG_W-1:0] vd;
    logic [7:0]             eew_loadstore;
    logic                   ls_idx;
    logic                   rd_wen;
    logic [`VEX_VREG_W-1:0] rd_sel;
    logic [`VEX_XLEN-1:0]   rd_data;
  } vex_mem_t;

  // element-wise op shared by the lanes and the reduction combine
  function automatic vex_word_u alu_calc(
    input vex_word_u a,
    input vex_word_u b,
    input valu_op_t  op,
    input minmax_t   mm,
    input sew_t      sew
  );
    logic      slt;
    logic      sltu;
    vex_word_u res;
    sltu = a.word < b.word;
    // signed compare only looks at the low element
    case (sew)
      SEW8:    slt = $signed(a.bytes[0]) < $signed(b.bytes[0]);
      SEW16:   slt = $signed(a.half[0]) < $signed(b.half[0]);
      default: slt = $signed(a.word) < $signed(b.word);
    endcase
    case (op)
      VALU_ADD: res.word = a.word + b.word;
      VALU_AND: res.word = a.word & b.word;
      VALU_OR:  res.word = a.word | b.word;
      VALU_XOR: res.word = a.word ^ b.word;
      VALU_MM: begin
        case (mm)
          MIN:     res = slt ? a : b;
          MINU:    res = sltu ? a : b;
          MAX:     res = slt ? b : a;
          default: res = sltu ? b : a;
        endcase
      end
      default:  res.word = '0;
    endcase
    return res;
  endfunction

endpackage

// ==== vex_lane_alu.sv ====
// ----------------------------
// one vector lane: source select and element-wise ALU
// instantiated once per lane in the execute top
// ----------------------------

`timescale 1ns/1ps

`include "vex_defs.svh"

module vex_lane_alu (
  input  logic                 CLK,
  input  logic                 nRST,
  input  vex_pkg::vex_issue_t  issue,
  input  logic [`VEX_XLEN-1:0] vs1,
  input  logic [`VEX_XLEN-1:0] vs2,
  output vex_pkg::vex_word_u   result,
  output logic                 busy
);

  vex_pkg::vex_word_u opa;
  vex_pkg::vex_word_u opb;
  logic               alu_valid;

  // operand a
  always_comb begin
    case (issue.rs1_type)
      vex_pkg::V: opa.word = vs1;
      vex_pkg::I: opa.word = issue.imm;
      vex_pkg::X: opa.word = issue.xs1;
      default:    opa.word = '0;
    endcase
  end

  // operand b takes its scalar from xs2
  always_comb begin
    case (issue.rs2_type)
      vex_pkg::V: opb.word = vs2;
      vex_pkg::I: opb.word = issue.imm;
      vex_pkg::X: opb.word = issue.xs2;
      default:    opb.word = '0;
    endcase
  end

  assign result = vex_pkg::alu_calc(opa, opb, issue.aluop, issue.minmax_type, issue.sew);

  // an ALU op writes a register and is not a memory access
  assign alu_valid = (|issue.wen) & ~(issue.load_ena | issue.store_ena);

  // occupancy marker seen by the hazard unit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
    end else begin
      busy <= alu_valid;
    end
  end

  // decode must never pair a register write with an unknown source
  a_rs1_type_legal : assert property (
    @(posedge CLK) disable iff (!nRST)
    (|issue.wen) |-> (issue.rs1_type inside {vex_pkg::V, vex_pkg::I, vex_pkg::X})
  );

endmodule

// ==== vex_addr_gen.sv ====
// ----------------------------
// load/store address generation for both lanes
// unit, strided, segment, full-register and indexed forms
// ----------------------------

`timescale 1ns/1ps

`include "vex_defs.svh"

module vex_addr_gen (
  input  vex_pkg::vex_issue_t  issue,
  input  logic [`VEX_XLEN-1:0] lane0_idx,
  input  logic [`VEX_XLEN-1:0] lane1_idx,
  output logic [`VEX_XLEN-1:0] addr0,
  output logic [`VEX_XLEN-1:0] addr1
);

  logic [`VEX_XLEN-1:0] step;
  logic [`VEX_XLEN-1:0] base;
  logic [`VEX_XLEN-1:0] stride;
  logic [`VEX_XLEN-1:0] idx0_scaled;
  logic [`VEX_XLEN-1:0] idx1_scaled;

  // bytes per element
  assign step = `VEX_XLEN'(issue.eew_loadstore) >> 3;

  // whole-register moves start right at xs1
  always_comb begin
    if (issue.fullreg) begin
      base = issue.xs1;
    end else begin
      base = issue.xs1 + `VEX_XLEN'(issue.nf_count) * step;
    end
  end

  always_comb begin
    case (issue.stride_type)
      vex_pkg::SEGMENT: stride = (`VEX_XLEN'(issue.nf) + 1) * step;
      vex_pkg::STRIDED: stride = issue.stride_val;
      default:          stride = `VEX_XLEN'(`VEX_DEFAULT_STRIDE);
    endcase
  end

  // element index scaled to bytes by SEW
  always_comb begin
    case (issue.sew)
      vex_pkg::SEW32: begin
        idx0_scaled = lane0_idx << 2;
        idx1_scaled = lane1_idx << 2;
      end
      vex_pkg::SEW16: begin
        idx0_scaled = lane0_idx << 1;
        idx1_scaled = lane1_idx << 1;
      end
      default: begin
        idx0_scaled = lane0_idx;
        idx1_scaled = lane1_idx;
      end
    endcase
  end

  assign addr0 = issue.ls_idx ? base + idx0_scaled : base;
  assign addr1 = issue.ls_idx ? base + idx1_scaled : base + stride;

endmodule

// ==== vex_result_select.sv ====
// ----------------------------
// builds the next memory bundle from lane results,
// addresses and the issue, plus scalar write-back
// ----------------------------

`timescale 1ns/1ps

`include "vex_defs.svh"

module vex_result_select (
  input  vex_pkg::vex_issue_t  issue,
  input  vex_pkg::vex_word_u   res0,
  input  vex_pkg::vex_word_u   res1,
  input  logic [`VEX_XLEN-1:0] addr0,
  input  logic [`VEX_XLEN-1:0] addr1,
  output vex_pkg::vex_mem_t    next_out
);

  vex_pkg::vex_word_u reduce_res;
  logic               ls;
  logic               move_sel;

  assign ls       = issue.load_ena | issue.store_ena;
  assign move_sel = issue.vmv_type != vex_pkg::NOT_VMV;

  // fold the two lane partials with the same op
  assign reduce_res = vex_pkg::alu_calc(res0, res1, issue.aluop, issue.minmax_type, issue.sew);

  always_comb begin
    next_out = '0;

    next_out.load_ena      = issue.load_ena;
    next_out.store_ena     = issue.store_ena;
    next_out.wen           = issue.wen;
    next_out.woffset0      = issue.woffset0;
    next_out.woffset1      = issue.woffset1;
    next_out.vd            = issue.vd;
    next_out.eew_loadstore = issue.eew_loadstore;
    next_out.ls_idx        = issue.ls_idx;
    next_out.rd_sel        = issue.rd_sel;

    // lane 0 word
    if (ls)                                  next_out.aluresult0 = addr0;
    else if (issue.reduction_ena)            next_out.aluresult0 = reduce_res.word;
    else if (issue.vmv_type == vex_pkg::S_X) next_out.aluresult0 = issue.vs1_lane0;
    else if (issue.vmv_type == vex_pkg::V_V) next_out.aluresult0 = issue.vs2_lane0;
    else                                     next_out.aluresult0 = res0.word;

    // lane 1 word
    if (ls)            next_out.aluresult1 = addr1;
    else if (move_sel) next_out.aluresult1 = issue.vs2_lane1;
    else               next_out.aluresult1 = res1.word;

    // vsetvl always returns vl to the scalar file
    next_out.rd_wen = issue.rd_wen | issue.config_type;
    if (issue.config_type)        next_out.rd_data = issue.vl;
    else if (issue.rd_scalar_src) next_out.rd_data = issue.vs2_lane0;
    else                          next_out.rd_data = '0;
  end

endmodule

// ==== vex_mem_latch.sv ====
// ----------------------------
// execute/memory pipeline register
// holds on stall, clears on flush
// ----------------------------

`timescale 1ns/1ps

module vex_mem_latch (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              stall,
  input  logic              flush,
  input  vex_pkg::vex_mem_t next_out,
  output vex_pkg::vex_mem_t mem_out
);

  // flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_out <= '0;
    end else if (flush) begin
      mem_out <= '0;
    end else if (!stall) begin
      mem_out <= next_out;
    end
  end

  // a memory op is either a load or a store
  a_ls_exclusive : assert property (
    @(posedge CLK) disable iff (!nRST)
    !(mem_out.load_ena && mem_out.store_ena)
  );

endmodule

// ==== vex_execute_top.sv ====
// ----------------------------
// vector execute stage, two lanes
// issue in from decode, one-cycle bundle out to memory
// ----------------------------

`timescale 1ns/1ps

`include "vex_defs.svh"

module vex_execute_top (
  input  logic                CLK,
  input  logic                nRST,
  input  vex_pkg::vex_issue_t issue,
  input  logic                stall,
  input  logic                flush,
  output vex_pkg::vex_mem_t   mem_out,
  output logic                busy
);

  vex_pkg::vex_word_u   res0;
  vex_pkg::vex_word_u   res1;
  logic                 lane0_busy;
  logic                 lane1_busy;
  logic [`VEX_XLEN-1:0] addr0;
  logic [`VEX_XLEN-1:0] addr1;
  vex_pkg::vex_mem_t    next_out;

  vex_lane_alu lane0_alu (
    .CLK    (CLK),
    .nRST   (nRST),
    .issue  (issue),
    .vs1    (issue.vs1_lane0),
    .vs2    (issue.vs2_lane0),
    .result (res0),
    .busy   (lane0_busy)
  );

  vex_lane_alu lane1_alu (
    .CLK    (CLK),
    .nRST   (nRST),
    .issue  (issue),
    .vs1    (issue.vs1_lane1),
    .vs2    (issue.vs2_lane1),
    .result (res1),
    .busy   (lane1_busy)
  );

  // indexed forms take the element index from vs2
  vex_addr_gen addr_gen (
    .issue     (issue),
    .lane0_idx (issue.vs2_lane0),
    .lane1_idx (issue.vs2_lane1),
    .addr0     (addr0),
    .addr1     (addr1)
  );

  vex_result_select result_sel (
    .issue    (issue),
    .res0     (res0),
    .res1     (res1),
    .addr0    (addr0),
    .addr1    (addr1),
    .next_out (next_out)
  );

  vex_mem_latch mem_latch (
    .CLK      (CLK),
    .nRST     (nRST),
    .stall    (stall),
    .flush    (flush),
    .next_out (next_out),
    .mem_out  (mem_out)
  );

  assign busy = lane0_busy | lane1_busy;

endmodule

// ==== vex_execute_tb.sv ====
// ----------------------------
// trace-driven testbench for the vector execute stage
// reads one issue per cycle from the trace file
// ----------------------------

`timescale 1ns/1ps

`include "vex_defs.svh"

module vex_execute_tb;

  typedef struct packed {
    vex_pkg::vex_issue_t  issue;
    logic                 stall;
    logic                 flush;
    logic [`VEX_XLEN-1:0] exp_ar0;
    logic [`VEX_XLEN-1:0] exp_ar1;
    logic                 exp_rd_wen;
    logic [`VEX_XLEN-1:0] exp_rd_data;
    logic                 exp_busy;
  } trace_rec_t;

  logic                CLK;
  logic                nRST;
  vex_pkg::vex_issue_t issue;
  logic                stall;
  logic                flush;
  vex_pkg::vex_mem_t   mem_out;
  logic                busy;

  trace_rec_t        recs[$];
  logic [31:0]       tok[0:47];
  int                ntok;
  int                errors;
  int                checks;
  int                cycles;
  int                cycle_limit;
  vex_pkg::vex_mem_t model;

  vex_execute_top vex_execute_top_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .issue   (issue),
    .stall   (stall),
    .flush   (flush),
    .mem_out (mem_out),
    .busy    (busy)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
      errors = errors + 1;
    end
  endtask

  // whitespace separated hex tokens into tok[]
  task automatic split_line(input string s);
    byte c;
    int  i;
    int  start;
    ntok = 0;
    start = -1;
    for (i = 0; i <= s.len(); i++) begin
      c = (i < s.len()) ? s.getc(i) : " ";
      if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
        if (start >= 0 && ntok < 48) begin
          tok[ntok] = s.substr(start, i - 1).atohex();
          ntok = ntok + 1;
        end
        start = -1;
      end else if (start < 0) begin
        start = i;
      end
    end
  endtask

  task automatic build_record(output trace_rec_t r);
    logic [7:0]  mask;
    logic [31:0] ops[0:7];
    int          k;
    r = '0;
    mask = tok[0][7:0];
    // operands the line does not use get random values
    for (k = 0; k < 8; k++) begin
      ops[k] = mask[7-k] ? tok[1+k] : $urandom();
    end
    r.issue.vs1_lane0     = ops[0];
    r.issue.vs1_lane1     = ops[1];
    r.issue.vs2_lane0     = ops[2];
    r.issue.vs2_lane1     = ops[3];
    r.issue.imm           = ops[4];
    r.issue.xs1           = ops[5];
    r.issue.xs2           = ops[6];
    r.issue.stride_val    = ops[7];
    r.issue.rs1_type      = vex_pkg::src_type_t'(tok[9][1:0]);
    r.issue.rs2_type      = vex_pkg::src_type_t'(tok[10][1:0]);
    r.issue.aluop         = vex_pkg::valu_op_t'(tok[11][2:0]);
    r.issue.minmax_type   = vex_pkg::minmax_t'(tok[12][1:0]);
    r.issue.sew           = vex_pkg::sew_t'(tok[13][1:0]);
    r.issue.reduction_ena = tok[14][0];
    r.issue.load_ena      = tok[15][0];
    r.issue.store_ena     = tok[16][0];
    r.issue.ls_idx        = tok[17][0];
    r.issue.stride_type   = vex_pkg::stride_t'(tok[18][1:0]);
    r.issue.eew_loadstore = tok[19][7:0];
    r.issue.nf            = tok[20][`VEX_NF_W-1:0];
    r.issue.nf_count      = tok[21][`VEX_NF_W-1:0];
    r.issue.fullreg       = tok[22][0];
    r.issue.vmv_type      = vex_pkg::vmv_t'(tok[23][1:0]);
    r.issue.wen           = tok[24][1:0];
    r.issue.woffset0      = tok[25][`VEX_OFFSET_W-1:0];
    r.issue.woffset1      = tok[26][`VEX_OFFSET_W-1:0];
    r.issue.vd            = tok[27][`VEX_VREG_W-1:0];
    r.issue.rd_wen        = tok[28][0];
    r.issue.rd_sel        = tok[29][`VEX_VREG_W-1:0];
    r.issue.rd_scalar_src = tok[30][0];
    r.issue.config_type   = tok[31][0];
    r.issue.vl            = tok[32];
    r.stall               = tok[33][0];
    r.flush               = tok[34][0];
    r.exp_ar0             = tok[35];
    r.exp_ar1             = tok[36];
    r.exp_rd_wen          = tok[37][0];
    r.exp_rd_data         = tok[38];
    r.exp_busy            = tok[39][0];
  endtask

  task automatic apply_record(input trace_rec_t r);
    issue = r.issue;
    stall = r.stall;
    flush = r.flush;
  endtask

  // pass-through fields follow the last accepted issue
  task automatic update_model(input trace_rec_t r);
    if (r.flush) begin
      model = '0;
    end else if (!r.stall) begin
      model.load_ena      = r.issue.load_ena;
      model.store_ena     = r.issue.store_ena;
      model.wen           = r.issue.wen;
      model.woffset0      = r.issue.woffset0;
      model.woffset1      = r.issue.woffset1;
      model.vd            = r.issue.vd;
      model.eew_loadstore = r.issue.eew_loadstore;
      model.ls_idx        = r.issue.ls_idx;
      model.rd_sel        = r.issue.rd_sel;
    end
  endtask

  task automatic check_record(input trace_rec_t r);
    check_value("load_ena", mem_out.load_ena, model.load_ena);
    check_value("store_ena", mem_out.store_ena, model.store_ena);
    check_value("aluresult0", mem_out.aluresult0, r.exp_ar0);
    check_value("aluresult1", mem_out.aluresult1, r.exp_ar1);
    check_value("wen", mem_out.wen, model.wen);
    check_value("woffset0", mem_out.woffset0, model.woffset0);
    check_value("woffset1", mem_out.woffset1, model.woffset1);
    check_value("vd", mem_out.vd, model.vd);
    check_value("eew_loadstore", mem_out.eew_loadstore, model.eew_loadstore);
    check_value("ls_idx", mem_out.ls_idx, model.ls_idx);
    check_value("rd_wen", mem_out.rd_wen, r.exp_rd_wen);
    check_value("rd_sel", mem_out.rd_sel, model.rd_sel);
    check_value("rd_data", mem_out.rd_data, r.exp_rd_data);
    check_value("busy", busy, r.exp_busy);
  endtask

  initial begin
    int         fd;
    int         rc;
    int         i;
    int         seed_ret;
    string      line;
    trace_rec_t r;
    CLK = 1'b0;
    nRST = 1'b0;
    issue = '0;
    stall = 1'b0;
    flush = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    cycle_limit = 1000;
    model = '0;
    seed_ret = $urandom(32'hacda3773);

    fd = $fopen("vex_execute_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file vex_execute_trace.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line.getc(0) != "#") begin
          split_line(line);
          if (ntok == 40) begin
            build_record(r);
            recs.push_back(r);
          end else if (ntok != 0) begin
            $display("malformed trace line with %0d fields", ntok);
            errors = errors + 1;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = recs.size() + 20;

    // first issue already sits on the inputs while reset is held
    if (recs.size() > 0) begin
      apply_record(recs[0]);
    end
    repeat (10) @(posedge CLK);
    #1;
    check_value("mem_out", mem_out, '0);
    check_value("busy", busy, 1'b0);
    nRST = 1'b1;

    for (i = 0; i < recs.size(); i++) begin
      @(posedge CLK);
      #1;
      // the next issue is on the inputs when this result is checked
      if (i + 1 < recs.size()) begin
        apply_record(recs[i + 1]);
      end else begin
        issue = '0;
        stall = 1'b0;
        flush = 1'b0;
      end
      #1;
      update_model(recs[i]);
      check_record(recs[i]);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
vex_pkg.sv
vex_lane_alu.sv
vex_addr_gen.sv
vex_result_select.sv
vex_mem_latch.sv
vex_execute_top.sv
vex_execute_tb.sv

// ==== vex_execute_trace.txt ====
# mask v1_0 v1_1 v2_0 v2_1 imm xs1 xs2 strv | r1t r2t op mm sew red ld st idx stt eew nf nfc full
# vmv wen wo0 wo1 vd rdw rds rsrc cfg vl stall flush | exp: ar0 ar1 rd_wen rd_data busy (hex)
f0 10 20 3 5 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 3 1 2 4 0 0 0 0 0 0 0 13 25 0 0 1
38 0 0 f0f0f0f 1234 ff0f 0 0 0 1 0 1 0 2 0 0 0 0 0 20 0 0 0 0 3 0 1 5 0 0 0 0 0 0 0 f0f 1204 0 0 1
34 0 0 f 100 0 f000 0 0 2 0 2 0 2 0 0 0 0 0 20 0 0 0 0 3 2 3 6 0 0 0 0 0 0 0 f00f f100 0 0 1
c2 ffff0000 aaaa 0 0 0 0 ffff 0 0 2 3 0 2 0 0 0 0 0 20 0 0 0 0 3 0 0 7 0 0 0 0 0 0 0 ffffffff 5555 0 0 1
0a 0 0 0 0 100 0 23 0 1 2 0 0 2 0 0 0 0 0 20 0 0 0 0 1 4 0 8 0 0 0 0 0 0 0 123 123 0 0 1
f0 80 7f 5 ff 0 0 0 0 0 0 4 0 0 0 0 0 0 0 8 0 0 0 0 3 0 0 a 0 0 0 0 0 0 0 80 ff 0 0 1
f0 80 7f 5 ff 0 0 0 0 0 0 4 2 0 0 0 0 0 0 8 0 0 0 0 3 0 0 a 0 0 0 0 0 0 0 5 7f 0 0 1
f0 80 7f 5 ff 0 0 0 0 0 0 4 1 0 0 0 0 0 0 8 0 0 0 0 3 0 0 a 0 0 0 0 0 0 0 5 7f 0 0 1
f0 1 10 2 20 0 0 0 0 0 0 0 0 2 1 0 0 0 0 20 0 0 0 0 1 0 0 b 0 0 0 0 0 0 0 33 30 0 0 1
f0 5 ffffffff 9 2 0 0 0 0 0 0 4 3 2 1 0 0 0 0 20 0 0 0 0 1 0 0 c 0 0 0 0 0 0 0 ffffffff ffffffff 0 0 1
90 dead 0 0 beef 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 2 3 0 0 d 0 0 0 0 0 0 0 dead beef 0 0 1
30 0 0 cafe f00d 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 1 3 0 0 e 0 0 0 0 0 0 0 cafe f00d 0 0 1
04 0 0 0 0 0 1000 0 0 0 0 0 0 2 0 1 0 0 0 20 0 0 0 0 3 0 0 f 0 0 0 0 0 0 0 1000 1004 0 0 0
05 0 0 0 0 0 2000 0 40 0 0 0 0 1 0 0 1 0 1 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2000 2040 0 0 0
04 0 0 0 0 0 3000 0 0 0 0 0 0 1 0 1 0 0 2 10 2 1 0 0 3 1 1 10 0 0 0 0 0 0 0 3002 3008 0 0 0
04 0 0 0 0 0 4000 0 0 0 0 0 0 2 0 1 0 0 0 20 0 3 1 0 3 0 0 11 0 0 0 0 0 0 0 4000 4004 0 0 0
34 0 0 3 7 0 5000 0 0 0 0 0 0 1 0 1 0 1 0 10 0 0 0 0 3 0 0 12 0 0 0 0 0 0 0 5006 500e 0 0 0
34 0 0 2 5 0 6000 0 0 0 0 0 0 2 0 0 1 1 0 20 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6008 6014 0 0 0
08 0 0 0 0 1 0 0 0 1 1 0 0 2 0 0 0 0 0 20 0 0 0 0 0 0 0 0 0 3 0 1 10 0 0 2 2 1 10 0
f0 1 1 abcd 1 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 0 0 0 0 1 7 1 0 0 0 0 abce 2 1 abcd 0
f0 100 200 1 2 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 3 0 0 9 0 0 0 0 0 0 0 101 202 0 0 1
f0 7 8 7 8 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 3 1 1 5 0 0 0 0 0 1 0 101 202 0 0 1
f0 7 8 7 8 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 3 1 1 5 0 0 0 0 0 1 0 101 202 0 0 1
f0 7 8 7 8 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 3 1 1 5 0 0 0 0 0 1 0 101 202 0 0 1
f0 7 8 7 8 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 3 1 1 5 0 0 0 0 0 0 0 e 10 0 0 1
f0 7 8 7 8 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 3 1 1 5 0 0 0 0 0 1 1 0 0 0 0 1
f0 1 1 1 1 0 0 0 0 0 0 0 0 2 0 0 0 0 0 20 0 0 0 0 0 0 0 3 0 0 0 0 0 0 1 0 0 0 0 0
f0 f 0 1 0 0 0 0 0 0 0 3 0 2 0 0 0 0 0 20 0 0 0 0 2 2 2 6 0 0 0 0 0 0 0 e 0 0 0 1
